// ==== Makefile ====
# Verilator build and run for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_bpu
FILELIST  ?= bpu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bpu.f ====
+incdir+.
bpu_pkg.sv
bpu_decode_stage.sv
bpu_lookup_stage.sv
bpu_select_stage.sv
bpu_top.sv
tb_bpu.sv

// ==== bpu_decode_stage.sv ====
`timescale 1ns/100ps
`include "bpu_settings.svh"

module bpu_decode_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  bpu_pkg::fetch_t      fetch_i,
    output bpu_pkg::lookup_req_t req_o
);
    import bpu_pkg::*;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    addr_t       pc;
    inst_t       inst;
    logic [6:0]  opcode;
    addr_t       b_imm;
    addr_t       j_imm;
    lookup_req_t req_d;
    lookup_req_t req_q;
    logic        valid_q;

    assign pc     = fetch_i.pc;
    assign inst   = fetch_i.inst;
    assign opcode = inst[6:0];

    // sign-extended B and J immediates
    assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        req_d         = '0;
        req_d.valid   = fetch_i.valid;
        req_d.pc      = pc;
        req_d.is_cond = (opcode == OP_BRANCH);
        req_d.is_jal  = (opcode == OP_JAL);
        req_d.is_jalr = (opcode == OP_JALR);

        // jalr target depends on rs1, so fall back to pc+4 here
        if (req_d.is_cond) begin
            req_d.direct_target = pc + b_imm;
        end else if (req_d.is_jal) begin
            req_d.direct_target = pc + j_imm;
        end else begin
            req_d.direct_target = pc + addr_t'(4);
        end

        req_d.bm_idx  = pc[`BPU_BM_IDX_HI:`BPU_BM_IDX_LO];
        req_d.btb_idx = pc[`BPU_BTB_IDX_HI:`BPU_BTB_IDX_LO];
        req_d.btb_tag = pc[`BPU_XLEN-1:`BPU_BTB_TAG_LO];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_i.valid) begin
            req_q <= req_d; // payload only on a real fetch
        end
    end

    always_comb begin
        req_o       = req_q;
        req_o.valid = valid_q;
    end

endmodule

// ==== bpu_lookup_stage.sv ====
`timescale 1ns/100ps
`include "bpu_settings.svh"

module bpu_lookup_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  bpu_pkg::lookup_req_t req_i,
    input  bpu_pkg::update_t     update_i,
    output bpu_pkg::lookup_rsp_t rsp_o
);
    import bpu_pkg::*;

    // bimodal counters and btb arrays
    sat_cnt_t bm_cnt     [0:`BPU_BM_ENTRIES-1];
    btb_tag_t btb_tag    [0:`BPU_BTB_ENTRIES-1];
    addr_t    btb_target [0:`BPU_BTB_ENTRIES-1];
    logic     btb_valid  [0:`BPU_BTB_ENTRIES-1];

    bm_idx_t     upd_bm_idx;
    btb_idx_t    upd_btb_idx;
    btb_tag_t    upd_btb_tag;
    sat_cnt_t    upd_cnt_cur;
    sat_cnt_t    upd_cnt_next;
    sat_cnt_t    rd_cnt;
    lookup_rsp_t rsp_d;
    lookup_rsp_t rsp_q;
    logic        valid_q;

    assign upd_bm_idx  = update_i.pc[`BPU_BM_IDX_HI:`BPU_BM_IDX_LO];
    assign upd_btb_idx = update_i.pc[`BPU_BTB_IDX_HI:`BPU_BTB_IDX_LO];
    assign upd_btb_tag = update_i.pc[`BPU_XLEN-1:`BPU_BTB_TAG_LO];
    assign upd_cnt_cur = bm_cnt[upd_bm_idx];

    // saturating step, sticks at 00 and 11
    always_comb begin
        upd_cnt_next = upd_cnt_cur;
        if (update_i.taken) begin
            if (upd_cnt_cur != 2'b11) begin
                upd_cnt_next = upd_cnt_cur + 2'd1;
            end
        end else if (upd_cnt_cur != 2'b00) begin
            upd_cnt_next = upd_cnt_cur - 2'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BPU_BM_ENTRIES; i++) begin
                bm_cnt[i] <= `BPU_CNT_INIT;
            end
            for (int i = 0; i < `BPU_BTB_ENTRIES; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else if (update_i.valid) begin
            bm_cnt[upd_bm_idx] <= upd_cnt_next;
            if (update_i.taken) begin
                btb_valid[upd_btb_idx] <= 1'b1;
            end
        end
    end

    // tag and target are qualified by btb_valid
    always_ff @(posedge clk) begin
        if (update_i.valid && update_i.taken) begin
            btb_tag[upd_btb_idx]    <= upd_btb_tag;
            btb_target[upd_btb_idx] <= update_i.target;
        end
    end

    // read side sees the old entry if an update lands on the same edge
    assign rd_cnt = bm_cnt[req_i.bm_idx];

    always_comb begin
        rsp_d               = '0;
        rsp_d.valid         = req_i.valid;
        rsp_d.pc            = req_i.pc;
        rsp_d.is_cond       = req_i.is_cond;
        rsp_d.is_jal        = req_i.is_jal;
        rsp_d.is_jalr       = req_i.is_jalr;
        rsp_d.direct_target = req_i.direct_target;
        rsp_d.bm_taken      = rd_cnt[1]; // msb of counter
        rsp_d.btb_hit       = btb_valid[req_i.btb_idx] &&
                              (btb_tag[req_i.btb_idx] == req_i.btb_tag);
        rsp_d.btb_target    = btb_target[req_i.btb_idx];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.valid) begin
            rsp_q <= rsp_d;
        end
    end

    always_comb begin
        rsp_o       = rsp_q;
        rsp_o.valid = valid_q;
    end

    // execute stage must never leave the training strobe floating
    a_update_valid_known : assert property (
        @(posedge clk) disable iff (rst) !$isunknown(update_i.valid)
    );

endmodule

// ==== bpu_pkg.sv ====
`include "bpu_settings.svh"

package bpu_pkg;

    typedef logic [`BPU_XLEN-1:0]                      addr_t;
    typedef logic [`BPU_XLEN-1:0]                      inst_t;
    typedef logic [`BPU_BM_IDX_HI-`BPU_BM_IDX_LO:0]    bm_idx_t;
    typedef logic [`BPU_BTB_IDX_HI-`BPU_BTB_IDX_LO:0]  btb_idx_t;
    typedef logic [`BPU_BTB_TAG_W-1:0]                 btb_tag_t;
    typedef logic [1:0]                                sat_cnt_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } fetch_t;

    // decode -> lookup
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        logic     is_cond;
        logic     is_jal;
        logic     is_jalr;
        addr_t    direct_target;
        bm_idx_t  bm_idx;
        btb_idx_t btb_idx;
        btb_tag_t btb_tag;
    } lookup_req_t;

    // lookup -> select
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  is_cond;
        logic  is_jal;
        logic  is_jalr;
        addr_t direct_target;
        logic  bm_taken;
        logic  btb_hit;
        addr_t btb_target;
    } lookup_rsp_t;

    // training from execute
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
    } update_t;

    typedef struct packed {
        logic  valid;
        logic  is_branch;
        logic  taken;
        addr_t target;
    } pred_t;

endpackage

// ==== bpu_select_stage.sv ====
`timescale 1ns/100ps

module bpu_select_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  bpu_pkg::lookup_rsp_t rsp_i,
    output bpu_pkg::pred_t       pred_o
);
    import bpu_pkg::*;

    logic  taken;
    addr_t seq_pc;
    pred_t pred_d;
    pred_t pred_q;
    logic  valid_q;

    assign seq_pc = rsp_i.pc + addr_t'(4);

    // jal always, jalr only when btb knows it, cond from bimodal
    assign taken = rsp_i.is_jal ||
                   (rsp_i.is_jalr && rsp_i.btb_hit) ||
                   (rsp_i.is_cond && rsp_i.bm_taken);

    always_comb begin
        pred_d           = '0;
        pred_d.valid     = rsp_i.valid;
        pred_d.is_branch = rsp_i.is_cond | rsp_i.is_jal | rsp_i.is_jalr;
        pred_d.taken     = taken;
        if (!taken) begin
            pred_d.target = seq_pc;
        end else if (rsp_i.btb_hit) begin
            pred_d.target = rsp_i.btb_target; // btb wins over computed offset
        end else begin
            pred_d.target = rsp_i.direct_target;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rsp_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_i.valid) begin
            pred_q <= pred_d;
        end
    end

    always_comb begin
        pred_o       = pred_q;
        pred_o.valid = valid_q;
    end

    // targets from decode and from btb training stay halfword aligned
    a_taken_target_aligned : assert property (
        @(posedge clk) disable iff (rst)
        (pred_o.valid && pred_o.taken) |-> !pred_o.target[0]
    );

endmodule

// ==== bpu_settings.svh ====
`ifndef BPU_SETTINGS_SVH
`define BPU_SETTINGS_SVH

// address and instruction width
`define BPU_XLEN 32

// table depths
`define BPU_BM_ENTRIES  512
`define BPU_BTB_ENTRIES 256

// bimodal index taken from pc[9:1]
`define BPU_BM_IDX_HI 9
`define BPU_BM_IDX_LO 1

// btb index from pc[9:2], tag is everything above
`define BPU_BTB_IDX_HI 9
`define BPU_BTB_IDX_LO 2
`define BPU_BTB_TAG_W  22
`define BPU_BTB_TAG_LO (`BPU_XLEN - `BPU_BTB_TAG_W)

`define BPU_CNT_INIT 2'b01 // weakly not taken

`endif

// ==== bpu_top.sv ====
`timescale 1ns/100ps

module bpu_top (
    input  logic             clk,
    input  logic             rst,
    input  bpu_pkg::fetch_t  fetch_i,
    input  bpu_pkg::update_t update_i,
    output bpu_pkg::pred_t   pred_o
);
    import bpu_pkg::*;

    lookup_req_t req; // decode -> lookup
    lookup_rsp_t rsp; // lookup -> select

    // stage 1, classify and index
    bpu_decode_stage u_decode (
        .clk     (clk),
        .rst     (rst),
        .fetch_i (fetch_i),
        .req_o   (req)
    );

    // stage 2, tables and training
    bpu_lookup_stage u_lookup (
        .clk      (clk),
        .rst      (rst),
        .req_i    (req),
        .update_i (update_i),
        .rsp_o    (rsp)
    );

    // stage 3, direction and target
    bpu_select_stage u_select (
        .clk    (clk),
        .rst    (rst),
        .rsp_i  (rsp),
        .pred_o (pred_o)
    );

endmodule

// ==== tb_bpu.sv ====
`timescale 1ns/100ps
`include "bpu_settings.svh"

module tb_bpu;
    import bpu_pkg::*;

    localparam int    TIMEOUT_CYCLES = 2000;
    localparam inst_t NOP            = 32'h0000_0013; // addi x0, x0, 0

    logic    clk;
    logic    rst;
    fetch_t  fetch_i;
    update_t update_i;
    pred_t   pred_o;

    // reference model tables
    sat_cnt_t m_cnt     [0:`BPU_BM_ENTRIES-1];
    logic     m_btb_vld [0:`BPU_BTB_ENTRIES-1];
    btb_tag_t m_btb_tag [0:`BPU_BTB_ENTRIES-1];
    addr_t    m_btb_tgt [0:`BPU_BTB_ENTRIES-1];

    addr_t  enc_off [inst_t]; // byte offset behind each encoded branch and jal
    pred_t  exp_q [$];
    int     due_q [$]; // edge count at which each prediction must show
    fetch_t pend_fetch;
    int     edge_cnt;
    logic   exp_valid;
    integer seed;

    bpu_top UUT (
        .clk      (clk),
        .rst      (rst),
        .fetch_i  (fetch_i),
        .update_i (update_i),
        .pred_o   (pred_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            abort_run("single bit compare failed");
        end
    endtask

    task automatic check_pred(input string name, input pred_t got, input pred_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got br=%b tk=%b tgt=%h expected br=%b tk=%b tgt=%h",
                     $time, name, got.is_branch, got.taken, got.target,
                     exp.is_branch, exp.taken, exp.target);
            abort_run("prediction compare failed");
        end
    endtask

    // instruction encoders taking byte offsets
    function automatic inst_t enc_branch(input addr_t off);
        inst_t i;
        i = {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
        enc_off[i] = off;
        return i;
    endfunction

    function automatic inst_t enc_jal(input addr_t off);
        inst_t i;
        i = {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
        enc_off[i] = off;
        return i;
    endfunction

    function automatic inst_t enc_jalr(input logic [11:0] imm);
        return {imm, 5'd1, 3'b000, 5'd0, 7'b1100111};
    endfunction

    function automatic fetch_t make_fetch(input addr_t pc, input inst_t inst);
        fetch_t f;
        f.valid = 1'b1;
        f.pc    = pc;
        f.inst  = inst;
        return f;
    endfunction

    function automatic update_t make_update(input addr_t pc, input logic taken, input addr_t tgt);
        update_t u;
        u.valid  = 1'b1;
        u.pc     = pc;
        u.taken  = taken;
        u.target = tgt;
        return u;
    endfunction

    function automatic pred_t make_pred(input logic br, input logic taken, input addr_t tgt);
        pred_t p;
        p.valid     = 1'b1;
        p.is_branch = br;
        p.taken     = taken;
        p.target    = tgt;
        return p;
    endfunction

    function automatic void model_reset();
        foreach (m_cnt[i]) m_cnt[i] = `BPU_CNT_INIT;
        foreach (m_btb_vld[i]) m_btb_vld[i] = 1'b0;
    endfunction

    function automatic void model_train(input update_t u);
        bm_idx_t  bi;
        btb_idx_t ti;
        bi = u.pc[`BPU_BM_IDX_HI:`BPU_BM_IDX_LO];
        ti = u.pc[`BPU_BTB_IDX_HI:`BPU_BTB_IDX_LO];
        if (u.taken) begin
            if (m_cnt[bi] != 2'b11) m_cnt[bi] = m_cnt[bi] + 2'd1;
            m_btb_vld[ti] = 1'b1;
            m_btb_tag[ti] = u.pc[`BPU_XLEN-1:`BPU_BTB_TAG_LO];
            m_btb_tgt[ti] = u.target;
        end else if (m_cnt[bi] != 2'b00) begin
            m_cnt[bi] = m_cnt[bi] - 2'd1;
        end
    endfunction

    function automatic pred_t model_predict(input fetch_t f);
        btb_idx_t ti;
        logic     ctl;
        logic     hit;
        logic     taken;
        addr_t    tgt;
        ti  = f.pc[`BPU_BTB_IDX_HI:`BPU_BTB_IDX_LO];
        hit = m_btb_vld[ti] && (m_btb_tag[ti] == f.pc[`BPU_XLEN-1:`BPU_BTB_TAG_LO]);
        ctl = 1'b1;
        case (f.inst[6:0])
            7'b1101111: taken = 1'b1; // jal
            7'b1100111: taken = hit;  // jalr needs a btb hit
            7'b1100011: taken = m_cnt[f.pc[`BPU_BM_IDX_HI:`BPU_BM_IDX_LO]][1];
            default: begin
                ctl   = 1'b0;
                taken = 1'b0;
            end
        endcase
        if (!taken) begin
            tgt = f.pc + 32'd4;
        end else if (hit) begin
            tgt = m_btb_tgt[ti];
        end else begin
            tgt = f.pc + enc_off[f.inst];
        end
        return make_pred(ctl, taken, tgt);
    endfunction

    // lookup of a fetch happens one edge after it is sampled
    always @(posedge clk) begin
        edge_cnt = edge_cnt + 1;
        if (edge_cnt > TIMEOUT_CYCLES) abort_run("timeout, tests did not finish in time");
        if (!rst) begin
            if (pend_fetch.valid) begin
                exp_q.push_back(model_predict(pend_fetch));
                due_q.push_back(edge_cnt + 1);
            end
            if (update_i.valid) model_train(update_i);
            pend_fetch = fetch_i;
        end
    end

    // outputs compared mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            exp_valid = (due_q.size() > 0) && (due_q[0] == edge_cnt);
            check_bit("pred_o.valid", pred_o.valid, exp_valid);
            if (exp_valid) begin
                void'(due_q.pop_front());
                check_pred("pred_o", pred_o, exp_q.pop_front());
            end
        end
    end

    task automatic drive_cycle(input fetch_t f, input update_t u);
        @(posedge clk);
        fetch_i  <= f;
        update_i <= u;
    endtask

    task automatic train(input addr_t pc, input logic taken, input addr_t tgt);
        drive_cycle('0, make_update(pc, taken, tgt));
    endtask

    task automatic predict_one(input addr_t pc, input inst_t inst, input pred_t exp);
        int waited;
        drive_cycle(make_fetch(pc, inst), '0);
        drive_cycle('0, '0);
        waited = 0;
        @(negedge clk);
        while (!pred_o.valid) begin
            if (waited > 4) abort_run("no prediction came back for a fetch");
            waited++;
            @(negedge clk);
        end
        check_pred("pred_o directed", pred_o, exp);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (fetch_i.valid || pend_fetch.valid || exp_q.size() != 0) begin
            if (n > 8) abort_run("pipeline did not drain");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic test_reset_idle();
        repeat (3) begin
            @(negedge clk);
            check_bit("pred_o.valid after reset", pred_o.valid, 1'b0);
        end
        predict_one(32'h0000_1000, NOP, make_pred(1'b0, 1'b0, 32'h0000_1004));
    endtask

    task automatic test_untrained();
        predict_one(32'h0000_1100, enc_branch(32'h20), make_pred(1'b1, 1'b0, 32'h0000_1104));
        predict_one(32'h0000_1200, enc_jal(32'hFFFF_FF00), make_pred(1'b1, 1'b1, 32'h0000_1100));
        predict_one(32'h0000_1300, enc_jalr(12'h010), make_pred(1'b1, 1'b0, 32'h0000_1304));
    endtask

    task automatic test_training();
        train(32'h0000_2040, 1'b1, 32'h0000_3000);
        train(32'h0000_2040, 1'b1, 32'h0000_3000); // counter now 11
        predict_one(32'h0000_2040, enc_branch(32'h40), make_pred(1'b1, 1'b1, 32'h0000_3000));
    endtask

    task automatic test_saturation();
        repeat (3) train(32'h0000_2040, 1'b0, 32'h0000_0000);
        predict_one(32'h0000_2040, enc_branch(32'h40), make_pred(1'b1, 1'b0, 32'h0000_2044));
        train(32'h0000_2040, 1'b1, 32'h0000_3000); // back to 01 only
        predict_one(32'h0000_2040, enc_branch(32'h40), make_pred(1'b1, 1'b0, 32'h0000_2044));
    endtask

    task automatic test_btb_tags();
        train(32'h0000_4080, 1'b1, 32'h0000_5000);
        predict_one(32'h0000_4080, enc_jalr(12'h0), make_pred(1'b1, 1'b1, 32'h0000_5000));
        // same btb index with a different tag
        predict_one(32'h0000_5080, enc_jalr(12'h0), make_pred(1'b1, 1'b0, 32'h0000_5084));
    endtask

    task automatic test_streaming();
        logic [31:0] r;
        logic [31:0] o;
        addr_t       pc;
        inst_t       inst;
        update_t     u;
        for (int n = 0; n < 40; n++) begin
            r  = $random(seed);
            o  = $random(seed);
            pc = 32'h0000_8000 | (r & 32'h0000_203C); // small pool with two tags
            case (r[1:0])
                2'd0: inst = NOP;
                2'd1: inst = enc_branch({{19{o[12]}}, o[12:1], 1'b0});
                2'd2: inst = enc_jal({{11{o[20]}}, o[20:1], 1'b0});
                default: inst = enc_jalr(o[11:0]);
            endcase
            u = '0;
            if (r[5]) u = make_update(32'h0000_8000 | (o & 32'h0000_203C), o[31],
                                      32'h0000_9000 | (r & 32'h0000_0FFC));
            drive_cycle(make_fetch(pc, inst), u);
        end
        drive_cycle('0, '0);
        wait_drain();
    endtask

    initial begin
        seed       = 12;
        rst        = 1'b1;
        fetch_i    = '0;
        update_i   = '0;
        pend_fetch = '0;
        edge_cnt   = 0;
        model_reset();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_reset_idle();
        test_untrained();
        test_training();
        test_saturation();
        test_btb_tags();
        test_streaming();

        $display("STATUS: PASS");
        $finish;
    end

endmodule
